//--- hdl/seq_pkg.sv
// shared types and constants of the microcoded sequencer
// word layout, routine categories, opcodes and vectors
`default_nettype none

package seq_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  opcat_t;   // routine base is {cat, 3'b000}
    typedef logic [6:0]  uaddr_t;
    typedef logic [11:0] uword_t;
    typedef logic [3:0]  intvec_t;  // one-hot reset/nmi/firq/irq

    // control word bits
    localparam int UW_FETCH    = 0;
    localparam int UW_DREAD    = 1;
    localparam int UW_NI       = 2;   // last step of the instruction
    localparam int UW_IDX_JMP  = 3;
    localparam int UW_IDX_RET  = 4;
    localparam int UW_BRANCH   = 5;
    localparam int UW_INT_EN   = 6;
    localparam int UW_LDPC_VEC = 7;
    localparam int UW_OFS      = 8;
    localparam int UW_EXT_HI   = 9;
    localparam int UW_EXT_LO   = 10;
    localparam int UW_ALU_GO   = 11;

    localparam opcat_t CAT_RESET     = 4'd0;
    localparam opcat_t CAT_NOPE      = 4'd1;
    localparam opcat_t CAT_ALU8_IMM  = 4'd2;
    localparam opcat_t CAT_ALU16_IMM = 4'd3;
    localparam opcat_t CAT_SBRANCH   = 4'd4;
    localparam opcat_t CAT_PARSE_IDX = 4'd5;
    localparam opcat_t CAT_LOAD8_IDX = 4'd6;
    localparam opcat_t CAT_IDX_R     = 4'd7;
    localparam opcat_t CAT_IDX_OFS8  = 4'd8;
    localparam opcat_t CAT_IDX_EXT   = 4'd9;
    localparam opcat_t CAT_NMI       = 4'd10;
    localparam opcat_t CAT_FIRQ      = 4'd11;
    localparam opcat_t CAT_IRQ       = 4'd12;
    localparam opcat_t CAT_BUSERROR  = 4'd13;
    localparam opcat_t CAT_DISPATCH  = 4'd14;  // opcode fetch, then jump to opcat

    localparam byte_t OP_NOP     = 8'h12;
    localparam byte_t OP_LDA_IMM = 8'h86;
    localparam byte_t OP_LDD_IMM = 8'hcc;
    localparam byte_t OP_BRA     = 8'h20;
    localparam byte_t OP_LDA_IDX = 8'ha6;

    localparam addr_t VEC_RESET = 16'h0100;
    localparam addr_t VEC_NMI   = 16'h0800;
    localparam addr_t VEC_FIRQ  = 16'h0900;
    localparam addr_t VEC_IRQ   = 16'h0a00;

    localparam int CC_I = 4;  // irq mask
    localparam int CC_F = 6;  // firq mask

    localparam intvec_t INTV_RESET = 4'b1000;
    localparam intvec_t INTV_NMI   = 4'b0100;
    localparam intvec_t INTV_FIRQ  = 4'b0010;
    localparam intvec_t INTV_IRQ   = 4'b0001;

    typedef enum logic [1:0] {IDLE, REQ, RELEASE} bus_state_t;

endpackage

`default_nettype wire

//--- hdl/op_decoder.sv
// opcode and postbyte decode into routine categories
`timescale 1ns/1ps
`default_nettype none

module op_decoder (
    input  wire seq_pkg::byte_t  op,
    input  wire seq_pkg::byte_t  postbyte,
    output seq_pkg::opcat_t      opcat,
    output seq_pkg::opcat_t      next_cat,
    output seq_pkg::opcat_t      idx_cat
);
    import seq_pkg::*;

    // instruction routine, plus the follow-up for indexed opcodes
    always_comb begin
        next_cat = CAT_BUSERROR;  // only read after an indexed parse
        case (op)
            OP_NOP: begin
                opcat = CAT_NOPE;
            end
            OP_LDA_IMM: begin
                opcat = CAT_ALU8_IMM;
            end
            OP_LDD_IMM: begin
                opcat = CAT_ALU16_IMM;
            end
            OP_BRA: begin
                opcat = CAT_SBRANCH;
            end
            OP_LDA_IDX: begin
                opcat    = CAT_PARSE_IDX;  // postbyte first
                next_cat = CAT_LOAD8_IDX;
            end
            default: begin
                opcat = CAT_BUSERROR;     // illegal opcode
            end
        endcase
    end

    // addressing mode from the low postbyte bits
    always_comb begin
        case (postbyte[1:0])
            2'd0:    idx_cat = CAT_IDX_R;
            2'd1:    idx_cat = CAT_IDX_OFS8;
            2'd2:    idx_cat = CAT_IDX_EXT;
            default: idx_cat = CAT_BUSERROR;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/int_arbiter.sv
// interrupt arbiter: nmi edge latch, masked firq/irq levels,
// priority choice on the last step of an instruction
`timescale 1ns/1ps
`default_nettype none

module int_arbiter (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 nmi_n,
    input  wire                 firq_n,
    input  wire                 irq_n,
    input  wire seq_pkg::byte_t cc,
    input  wire                 ni,
    output logic                int_take,
    output seq_pkg::opcat_t     int_cat,
    output seq_pkg::intvec_t    int_vec
);
    import seq_pkg::*;

    logic    nmi_l;     // last nmi_n
    logic    nmi_pend;
    logic    firq_ok;
    logic    irq_ok;
    intvec_t vec_nx;

    assign firq_ok  = !firq_n && !cc[CC_F];
    assign irq_ok   = !irq_n && !cc[CC_I];
    assign int_take = ni && (nmi_pend || firq_ok || irq_ok);

    always_comb begin
        int_cat = CAT_IRQ;  // only meaningful with int_take
        vec_nx  = INTV_IRQ;
        if (nmi_pend) begin
            int_cat = CAT_NMI;
            vec_nx  = INTV_NMI;
        end else if (firq_ok) begin
            int_cat = CAT_FIRQ;
            vec_nx  = INTV_FIRQ;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nmi_l    <= 1'b1;
            nmi_pend <= 1'b0;
            int_vec  <= INTV_RESET;  // reset routine shows 1000
        end else begin
            nmi_l <= nmi_n;
            if (int_take && nmi_pend) begin
                nmi_pend <= 1'b0;
            end
            if (nmi_l && !nmi_n) begin
                nmi_pend <= 1'b1;    // new edge wins over the clear
            end
            if (int_take) begin
                int_vec <= vec_nx;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ucode_rom.sv
// microcode store, one registered word per cycle
`timescale 1ns/1ps
`default_nettype none

module ucode_rom (
    input  wire                  clk,
    input  wire                  rst,
    input  wire seq_pkg::uaddr_t uaddr,
    output seq_pkg::uword_t      uword
);
    import seq_pkg::*;

    localparam uword_t M_FETCH    = uword_t'(1) << UW_FETCH;
    localparam uword_t M_DREAD    = uword_t'(1) << UW_DREAD;
    localparam uword_t M_NI       = uword_t'(1) << UW_NI;
    localparam uword_t M_IDX_JMP  = uword_t'(1) << UW_IDX_JMP;
    localparam uword_t M_IDX_RET  = uword_t'(1) << UW_IDX_RET;
    localparam uword_t M_BRANCH   = uword_t'(1) << UW_BRANCH;
    localparam uword_t M_INT_EN   = uword_t'(1) << UW_INT_EN;
    localparam uword_t M_LDPC_VEC = uword_t'(1) << UW_LDPC_VEC;
    localparam uword_t M_OFS      = uword_t'(1) << UW_OFS;
    localparam uword_t M_EXT_HI   = uword_t'(1) << UW_EXT_HI;
    localparam uword_t M_EXT_LO   = uword_t'(1) << UW_EXT_LO;
    localparam uword_t M_ALU_GO   = uword_t'(1) << UW_ALU_GO;

    // same address while stalled gives the same word back
    always_ff @(posedge clk) begin
        if (rst) begin
            uword <= '0;
        end else begin
            case (uaddr)
                {CAT_RESET, 3'd0}:     uword <= M_INT_EN | M_LDPC_VEC;
                {CAT_RESET, 3'd1}:     uword <= M_NI;
                {CAT_DISPATCH, 3'd0}:  uword <= M_FETCH;  // opcode
                {CAT_DISPATCH, 3'd1}:  uword <= '0;       // jump to opcat
                {CAT_NOPE, 3'd0}:      uword <= M_NI;
                {CAT_ALU8_IMM, 3'd0}:  uword <= M_FETCH;
                {CAT_ALU8_IMM, 3'd1}:  uword <= M_ALU_GO | M_NI;
                {CAT_ALU16_IMM, 3'd0}: uword <= M_FETCH;
                {CAT_ALU16_IMM, 3'd1}: uword <= M_FETCH;
                {CAT_ALU16_IMM, 3'd2}: uword <= M_ALU_GO | M_NI;
                {CAT_SBRANCH, 3'd0}:   uword <= M_FETCH;  // offset
                {CAT_SBRANCH, 3'd1}:   uword <= M_BRANCH | M_NI;
                {CAT_PARSE_IDX, 3'd0}: uword <= M_FETCH;  // postbyte
                {CAT_PARSE_IDX, 3'd1}: uword <= M_IDX_JMP;
                {CAT_IDX_R, 3'd0}:     uword <= M_IDX_RET;
                {CAT_IDX_OFS8, 3'd0}:  uword <= M_FETCH;
                {CAT_IDX_OFS8, 3'd1}:  uword <= M_OFS;
                {CAT_IDX_OFS8, 3'd2}:  uword <= M_IDX_RET;
                {CAT_IDX_EXT, 3'd0}:   uword <= M_FETCH | M_EXT_HI;
                {CAT_IDX_EXT, 3'd1}:   uword <= M_FETCH | M_EXT_LO;
                {CAT_IDX_EXT, 3'd2}:   uword <= M_IDX_RET;
                {CAT_LOAD8_IDX, 3'd0}: uword <= M_DREAD;
                {CAT_LOAD8_IDX, 3'd1}: uword <= M_ALU_GO | M_NI;
                {CAT_NMI, 3'd0}:       uword <= M_INT_EN | M_LDPC_VEC;
                {CAT_NMI, 3'd1}:       uword <= M_NI;
                {CAT_FIRQ, 3'd0}:      uword <= M_INT_EN | M_LDPC_VEC;
                {CAT_FIRQ, 3'd1}:      uword <= M_NI;
                {CAT_IRQ, 3'd0}:       uword <= M_INT_EN | M_LDPC_VEC;
                {CAT_IRQ, 3'd1}:       uword <= M_NI;
                default:               uword <= '0;  // bus error slots too
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/ucode_seq.sv
// microcode sequencer: next address select, stall on memory,
// opcode dispatch, indexed jumps and bus-error freeze
`timescale 1ns/1ps
`default_nettype none

module ucode_seq (
    input  wire                   clk,
    input  wire                   rst,
    input  wire seq_pkg::uword_t  uword,
    input  wire                   mem_busy,
    input  wire seq_pkg::byte_t   last_byte,
    input  wire seq_pkg::opcat_t  opcat,
    input  wire seq_pkg::opcat_t  next_cat,
    input  wire seq_pkg::opcat_t  idx_cat,
    input  wire                   int_take,
    input  wire seq_pkg::opcat_t  int_cat,
    output seq_pkg::uaddr_t       uaddr,
    output seq_pkg::byte_t        op,
    output logic                  buserror
);
    import seq_pkg::*;

    uaddr_t cur_addr;  // address of the word now in uword
    opcat_t nx_cat;    // follow-up routine of an indexed opcode
    logic   primed;    // first word after reset is loaded
    logic   frozen;
    logic   access;
    logic   stall;
    logic   op_fetch;
    logic   op_jump;

    assign access   = uword[UW_FETCH] | uword[UW_DREAD];
    assign stall    = !primed || (access && mem_busy);
    assign op_fetch = (cur_addr == {CAT_DISPATCH, 3'd0});
    assign op_jump  = (cur_addr == {CAT_DISPATCH, 3'd1});
    assign buserror = frozen;

    always_comb begin
        if (frozen || stall) begin
            uaddr = cur_addr;
        end else if (uword[UW_IDX_RET]) begin
            uaddr = {nx_cat, 3'd0};
        end else if (uword[UW_IDX_JMP]) begin
            uaddr = {idx_cat, 3'd0};           // postbyte mode
        end else if (uword[UW_NI]) begin
            uaddr = int_take ? {int_cat, 3'd0} : {CAT_DISPATCH, 3'd0};
        end else if (op_jump) begin
            uaddr = {opcat, 3'd0};
        end else begin
            uaddr = cur_addr + 7'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_addr <= {CAT_RESET, 3'd0};
            primed   <= 1'b0;
            frozen   <= 1'b0;
        end else begin
            cur_addr <= uaddr;
            primed   <= 1'b1;
            if (uaddr[6:3] == CAT_BUSERROR) begin
                frozen <= 1'b1;  // held until rst
            end
        end
    end

    // opcode and follow-up category
    always_ff @(posedge clk) begin
        if (op_fetch && !stall) begin
            op <= last_byte;     // opcode byte just arrived
        end
        if (op_jump) begin
            nx_cat <= next_cat;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pc_bus_port.sv
// program counter, data address and four-phase req/ack read master
`timescale 1ns/1ps
`default_nettype none

module pc_bus_port (
    input  wire                   clk,
    input  wire                   rst,
    input  wire seq_pkg::uword_t  uword,
    input  wire seq_pkg::addr_t   xreg,
    input  wire                   branch,
    input  wire seq_pkg::intvec_t int_vec,
    input  wire                   mem_ack,
    input  wire seq_pkg::byte_t   mem_rdata,
    output logic                  mem_busy,
    output seq_pkg::byte_t        last_byte,
    output logic                  mem_req,
    output seq_pkg::addr_t        mem_addr,
    output seq_pkg::intvec_t      intvec
);
    import seq_pkg::*;

    bus_state_t state;
    addr_t      pc;
    addr_t      daddr;     // data address for DREAD
    addr_t      vec_addr;
    addr_t      ofs;
    logic       fetch;
    logic       access;
    logic       start;
    logic       capture;

    assign fetch   = uword[UW_FETCH];
    assign access  = fetch | uword[UW_DREAD];
    assign start   = (state == IDLE) && access;
    assign capture = (state == REQ) && mem_ack;
    assign ofs     = {{8{last_byte[7]}}, last_byte};  // signed 8-bit
    assign mem_req = (state == REQ);
    assign intvec  = uword[UW_INT_EN] ? int_vec : '0;

    always_comb begin
        case (state)
            IDLE:    mem_busy = access;
            REQ:     mem_busy = 1'b1;
            default: mem_busy = mem_ack;  // done once ack drops
        endcase
    end

    always_comb begin
        case (int_vec)
            INTV_NMI:  vec_addr = VEC_NMI;
            INTV_FIRQ: vec_addr = VEC_FIRQ;
            INTV_IRQ:  vec_addr = VEC_IRQ;
            default:   vec_addr = VEC_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc    <= VEC_RESET;
        end else begin
            case (state)
                IDLE: begin
                    if (access) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (mem_ack) begin
                        state <= RELEASE;  // req drops here
                    end
                end
                default: begin
                    if (!mem_ack) begin
                        state <= IDLE;
                    end
                end
            endcase
            if (capture && fetch) begin
                pc <= pc + 16'd1;
            end else if (uword[UW_LDPC_VEC]) begin
                pc <= vec_addr;
            end else if (uword[UW_BRANCH] && branch) begin
                pc <= pc + ofs;
            end
        end
    end

    // address and data registers
    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr <= fetch ? pc : daddr;
        end
        if (capture) begin
            last_byte <= mem_rdata;
        end
        if (capture && uword[UW_EXT_HI]) begin
            daddr[15:8] <= mem_rdata;
        end else if (capture && uword[UW_EXT_LO]) begin
            daddr[7:0] <= mem_rdata;
        end else if (uword[UW_IDX_JMP]) begin
            daddr <= xreg;           // indexed base
        end else if (uword[UW_OFS]) begin
            daddr <= daddr + ofs;
        end
    end

endmodule

`default_nettype wire

//--- hdl/seq_top.sv
// microcoded instruction sequencer top level
`timescale 1ns/1ps
`default_nettype none

module seq_top (
    input  wire                    clk,
    input  wire                    rst,
    output logic                   mem_req,
    output seq_pkg::addr_t         mem_addr,
    input  wire                    mem_ack,
    input  wire seq_pkg::byte_t    mem_rdata,
    input  wire seq_pkg::byte_t    cc,
    input  wire seq_pkg::addr_t    xreg,
    input  wire                    branch,
    input  wire                    nmi_n,
    input  wire                    firq_n,
    input  wire                    irq_n,
    output seq_pkg::uword_t        ctl,
    output seq_pkg::intvec_t       intvec,
    output logic                   buserror
);
    import seq_pkg::*;

    uaddr_t  uaddr;
    byte_t   op;
    byte_t   last_byte;
    opcat_t  opcat;
    opcat_t  next_cat;
    opcat_t  idx_cat;
    opcat_t  int_cat;
    intvec_t int_vec;
    logic    int_take;
    logic    mem_busy;

    op_decoder u_dec (
        .op       (op),
        .postbyte (last_byte),
        .opcat    (opcat),
        .next_cat (next_cat),
        .idx_cat  (idx_cat)
    );

    int_arbiter u_int (
        .clk      (clk),
        .rst      (rst),
        .nmi_n    (nmi_n),
        .firq_n   (firq_n),
        .irq_n    (irq_n),
        .cc       (cc),
        .ni       (ctl[UW_NI]),
        .int_take (int_take),
        .int_cat  (int_cat),
        .int_vec  (int_vec)
    );

    ucode_rom u_rom (
        .clk   (clk),
        .rst   (rst),
        .uaddr (uaddr),
        .uword (ctl)
    );

    ucode_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .uword     (ctl),
        .mem_busy  (mem_busy),
        .last_byte (last_byte),
        .opcat     (opcat),
        .next_cat  (next_cat),
        .idx_cat   (idx_cat),
        .int_take  (int_take),
        .int_cat   (int_cat),
        .uaddr     (uaddr),
        .op        (op),
        .buserror  (buserror)
    );

    pc_bus_port u_port (
        .clk       (clk),
        .rst       (rst),
        .uword     (ctl),
        .xreg      (xreg),
        .branch    (branch),
        .int_vec   (int_vec),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_busy  (mem_busy),
        .last_byte (last_byte),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .intvec    (intvec)
    );

endmodule

`default_nettype wire

//--- bench/seq_checker.sv
// protocol and control-output assertions for the sequencer top level
`timescale 1ns/1ps
`default_nettype none

module seq_checker (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 mem_req,
    input  wire                 mem_ack,
    input  wire seq_pkg::addr_t mem_addr,
    input  wire                 buserror
);

    // req stays up until the memory answers
    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack rose");

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req |=> !mem_req || $stable(mem_addr))
        else $error("mem_addr changed during a request");

    err_sticky: assert property (@(posedge clk) disable iff (rst)
        buserror |=> buserror)
        else $error("buserror fell without reset");

endmodule

bind seq_top seq_checker i_chk (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .mem_addr (mem_addr),
    .buserror (buserror)
);

`default_nettype wire

//--- bench/seq_tb.sv
// testbench for the microcoded sequencer
// memory responder with random ack delay, directed tests per behavior
`timescale 1ns/1ps
`default_nettype none

module seq_tb;
    import seq_pkg::*;

    localparam int N_TESTS     = 5;
    localparam int TEST_CYCLES = 400;
    localparam int T_CLK       = 4;

    logic    clk;
    logic    rst;
    logic    mem_req;
    logic    mem_ack;
    logic    branch;
    logic    nmi_n;
    logic    firq_n;
    logic    irq_n;
    logic    buserror;
    addr_t   mem_addr;
    addr_t   xreg;
    byte_t   mem_rdata;
    byte_t   cc;
    uword_t  ctl;
    intvec_t intvec;

    byte_t       mem [0:65535];
    addr_t       req_log[$];    // every request address in order
    addr_t       exp_reads[$];
    intvec_t     vec_log[$];    // one entry per cycle with intvec shown
    logic [31:0] lfsr;
    int          errors;
    int          checks;

    seq_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .cc        (cc),
        .xreg      (xreg),
        .branch    (branch),
        .nmi_n     (nmi_n),
        .firq_n    (firq_n),
        .irq_n     (irq_n),
        .ctl       (ctl),
        .intvec    (intvec),
        .buserror  (buserror)
    );

    always #(T_CLK / 2) clk = ~clk;

    // taps 32,22,2,1
    function automatic int take_bits(input int n);
        logic fb;
        int   v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // four-phase responder with 0 to 3 cycles of ack delay
    always begin : responder
        int wait_n;
        @(posedge clk);
        #1;
        if (mem_req && !mem_ack && !rst) begin
            req_log.push_back(mem_addr);
            wait_n = take_bits(2);
            repeat (wait_n) begin
                @(posedge clk);
                #1;
            end
            mem_rdata = mem[mem_addr];
            mem_ack   = 1'b1;
            while (mem_req) begin
                @(posedge clk);
                #1;
            end
            mem_ack = 1'b0;
        end
    end

    always begin : vec_monitor
        @(posedge clk);
        #1;
        if (!rst && intvec != '0) begin
            vec_log.push_back(intvec);
        end
    end

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    // odd fill bytes, none of them a legal opcode
    task automatic fill_mem();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = (a[15:8] ^ a[7:0]) | 8'h01;
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        req_log.delete();
        vec_log.delete();
        exp_reads.delete();
        check("reset ctl", 16'h0000, 16'(ctl));
        check("reset mem_req", 16'h0000, 16'(mem_req));
        check("reset intvec", 16'h0000, 16'(intvec));
        check("reset buserror", 16'h0000, 16'(buserror));
    endtask

    task automatic wait_reads(input string name, input int n);
        int cyc;
        cyc = 0;
        while (req_log.size() < n && cyc < TEST_CYCLES) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (req_log.size() < n) begin
            report_error($sformatf("%s: only %0d of %0d memory reads seen",
                                   name, req_log.size(), n));
        end
    endtask

    task automatic wait_intvec(input string name, input intvec_t v);
        int cyc;
        cyc = 0;
        while (intvec != v && cyc < TEST_CYCLES) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (intvec != v) begin
            report_error($sformatf("%s: intvec %b never shown", name, v));
        end
    endtask

    task automatic wait_buserror(input string name);
        int cyc;
        cyc = 0;
        while (!buserror && cyc < TEST_CYCLES) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!buserror) begin
            report_error($sformatf("%s: buserror never rose", name));
        end
    endtask

    task automatic check_reads(input string name);
        for (int i = 0; i < exp_reads.size(); i++) begin
            if (i < req_log.size()) begin
                check(name, exp_reads[i], req_log[i]);
            end
        end
    endtask

    task automatic end_test(input string name, input int start_errs);
        if (errors == start_errs) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - start_errs);
        end
    endtask

    task automatic test_reset_fetch();
        int e0;
        e0 = errors;
        fill_mem();
        mem[16'h0100] = OP_NOP;
        mem[16'h0101] = OP_LDA_IMM;
        mem[16'h0102] = 8'h3c;
        mem[16'h0103] = OP_LDD_IMM;
        mem[16'h0104] = 8'h12;
        mem[16'h0105] = 8'h34;
        mem[16'h0106] = OP_NOP;
        reset_dut();
        wait_reads("reset_fetch", 7);
        for (int i = 0; i < 7; i++) begin
            exp_reads.push_back(VEC_RESET + 16'(i));  // one byte after another
        end
        check_reads("reset_fetch addr");
        check("reset_fetch vec count", 16'd1, 16'(vec_log.size()));
        if (vec_log.size() > 0) begin
            check("reset_fetch intvec", 16'(INTV_RESET), 16'(vec_log[0]));
        end
        end_test("reset_fetch", e0);
    endtask

    task automatic test_branch();
        int e0;
        e0 = errors;
        fill_mem();
        mem[16'h0100] = OP_BRA;
        mem[16'h0101] = 8'h10;     // 0x102 + 16
        mem[16'h0112] = OP_BRA;
        mem[16'h0113] = 8'hf0;     // 0x114 - 16
        mem[16'h0104] = OP_NOP;
        branch = 1'b1;
        reset_dut();
        wait_reads("branch_taken", 5);
        exp_reads = '{16'h0100, 16'h0101, 16'h0112, 16'h0113, 16'h0104};
        check_reads("branch_taken addr");
        branch = 1'b0;
        reset_dut();
        wait_reads("branch_not", 3);
        exp_reads = '{16'h0100, 16'h0101, 16'h0102};
        check_reads("branch_not addr");
        end_test("branch", e0);
    endtask

    task automatic test_indexed();
        int e0;
        e0 = errors;
        fill_mem();
        mem[16'h0100] = OP_LDA_IDX;
        mem[16'h0101] = 8'h00;     // register indirect
        mem[16'h0102] = OP_LDA_IDX;
        mem[16'h0103] = 8'h01;     // 8-bit offset
        mem[16'h0104] = 8'hfe;
        mem[16'h0105] = OP_LDA_IDX;
        mem[16'h0106] = 8'h02;     // extended
        mem[16'h0107] = 8'h45;
        mem[16'h0108] = 8'h67;
        xreg = 16'h3000;
        reset_dut();
        wait_reads("indexed", 12);
        exp_reads = '{16'h0100, 16'h0101, 16'h3000,
                      16'h0102, 16'h0103, 16'h0104, 16'h2ffe,
                      16'h0105, 16'h0106, 16'h0107, 16'h0108, 16'h4567};
        check_reads("indexed addr");
        end_test("indexed", e0);
    endtask

    task automatic test_interrupts();
        int e0;
        e0 = errors;
        fill_mem();
        mem[VEC_NMI]  = OP_NOP;
        mem[VEC_FIRQ] = OP_NOP;
        mem[VEC_IRQ]  = OP_NOP;
        // all three together with levels released once served
        cc     = 8'h00;
        nmi_n  = 1'b0;
        firq_n = 1'b0;
        irq_n  = 1'b0;
        reset_dut();
        wait_intvec("int_prio", INTV_FIRQ);
        firq_n = 1'b1;
        wait_intvec("int_prio", INTV_IRQ);
        irq_n = 1'b1;
        wait_reads("int_prio", 1);
        exp_reads = '{VEC_IRQ};
        check_reads("int_prio addr");
        check("int_prio vec count", 16'd4, 16'(vec_log.size()));
        if (vec_log.size() >= 4) begin
            check("int_prio vec0", 16'(INTV_RESET), 16'(vec_log[0]));
            check("int_prio vec1", 16'(INTV_NMI), 16'(vec_log[1]));
            check("int_prio vec2", 16'(INTV_FIRQ), 16'(vec_log[2]));
            check("int_prio vec3", 16'(INTV_IRQ), 16'(vec_log[3]));
        end
        // firq alone runs code at its vector
        nmi_n  = 1'b1;
        firq_n = 1'b0;
        reset_dut();
        wait_intvec("firq_vec", INTV_FIRQ);
        firq_n = 1'b1;
        wait_reads("firq_vec", 1);
        exp_reads = '{VEC_FIRQ};
        check_reads("firq_vec addr");
        // masked levels
        nmi_n    = 1'b1;
        firq_n   = 1'b0;
        irq_n    = 1'b0;
        cc[CC_F] = 1'b1;
        cc[CC_I] = 1'b1;
        mem[16'h0100] = OP_NOP;
        mem[16'h0101] = OP_NOP;
        mem[16'h0102] = OP_NOP;
        reset_dut();
        wait_reads("int_mask", 3);
        exp_reads = '{16'h0100, 16'h0101, 16'h0102};
        check_reads("int_mask addr");
        check("int_mask vec count", 16'd1, 16'(vec_log.size()));
        // nmi held low is one edge only
        cc     = 8'h00;
        firq_n = 1'b1;
        irq_n  = 1'b1;
        nmi_n  = 1'b0;
        mem[VEC_NMI + 16'd1] = OP_NOP;
        mem[VEC_NMI + 16'd2] = OP_NOP;
        reset_dut();
        wait_reads("nmi_once", 3);
        exp_reads = '{VEC_NMI, VEC_NMI + 16'd1, VEC_NMI + 16'd2};
        check_reads("nmi_once addr");
        check("nmi_once vec count", 16'd2, 16'(vec_log.size()));
        if (vec_log.size() >= 2) begin
            check("nmi_once vec1", 16'(INTV_NMI), 16'(vec_log[1]));
        end
        nmi_n = 1'b1;
        end_test("interrupts", e0);
    endtask

    task automatic test_bus_error();
        int e0;
        e0 = errors;
        fill_mem();
        mem[16'h0100] = 8'h01;     // not an opcode
        reset_dut();
        wait_buserror("buserr_op");
        repeat (20) @(posedge clk);  // window for any stray request
        #1;
        check("buserr_op reads", 16'd1, 16'(req_log.size()));
        check("buserr_op flag", 16'd1, 16'(buserror));
        mem[16'h0100] = OP_LDA_IDX;
        mem[16'h0101] = 8'h03;     // illegal postbyte mode
        reset_dut();
        wait_buserror("buserr_pb");
        repeat (20) @(posedge clk);
        #1;
        check("buserr_pb reads", 16'd2, 16'(req_log.size()));
        exp_reads = '{16'h0100, 16'h0101};
        check_reads("buserr_pb addr");
        check("buserr_pb flag", 16'd1, 16'(buserror));
        end_test("bus_error", e0);
    endtask

    initial begin : watchdog
        #(N_TESTS * TEST_CYCLES * T_CLK);
        $display("watchdog: run did not finish within %0d cycles", N_TESTS * TEST_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        mem_ack   = 1'b0;
        mem_rdata = 8'h00;
        cc        = 8'h00;
        xreg      = 16'h0000;
        branch    = 1'b0;
        nmi_n     = 1'b1;
        firq_n    = 1'b1;
        irq_n     = 1'b1;
        lfsr      = 32'h0a5c_00e0;
        errors    = 0;
        checks    = 0;
        test_reset_fetch();
        test_branch();
        test_indexed();
        test_interrupts();
        test_bus_error();
        $display("tests: %0d, checks: %0d, errors: %0d", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hdl/seq_pkg.sv
hdl/op_decoder.sv
hdl/int_arbiter.sv
hdl/ucode_rom.sv
hdl/ucode_seq.sv
hdl/pc_bus_port.sv
hdl/seq_top.sv
bench/seq_checker.sv
bench/seq_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the sequencer testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module seq_tb -o seq_sim &&
./obj_dir/seq_sim | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" ||
{ echo "simulation failed" >&2; exit 1; }
